// ==== sources.f ====
+incdir+dv
hdl/la_core_pkg.sv
hdl/la_decode.sv
hdl/la_execute.sv
hdl/la_result.sv
hdl/la_core_top.sv
dv/la_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module la_core_tb -o sim_la_core

out=$(./obj_dir/sim_la_core)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi

// ==== dv/la_core_model.svh ====
// LoongArch pipeline reference model

`ifndef LA_CORE_MODEL_SVH
`define LA_CORE_MODEL_SVH

// one issue slot, imm also carries the raw code field or the whole illegal word
typedef struct packed {
  logic               valid;
  logic               squashed;
  la_core_pkg::op_e   op;
  la_core_pkg::word_t pc;
  la_core_pkg::areg_t rd;
  la_core_pkg::areg_t rj;
  la_core_pkg::areg_t rk;
  la_core_pkg::word_t imm;
} slot_t;

// what the commit stage should show for one retiring slot
typedef struct packed {
  logic                commit;
  logic                we;
  la_core_pkg::areg_t  rd;
  la_core_pkg::word_t  wdata;
  la_core_pkg::word_t  pc;
  logic                redirect;
  la_core_pkg::word_t  target;
  la_core_pkg::cause_e cause;
  logic [5:0]          ecode;
  logic                idle_redir;
} retire_t;

la_core_pkg::word_t m_regs [32];
la_core_pkg::word_t m_era;
logic               m_lock;
slot_t              pipe_q [$];

// ==============================
// retire prediction
// ==============================
function automatic retire_t model_retire(input slot_t s);
  retire_t            r;
  la_core_pkg::word_t a;
  la_core_pkg::word_t b;
  la_core_pkg::word_t res;
  r = '0;
  if (!s.valid || s.squashed) begin
    return r;
  end
  a = m_regs[s.rj];
  b = m_regs[s.rk];
  res = '0;
  r.pc = s.pc;
  case (s.op)
    la_core_pkg::OP_ADD:   res = a + b;
    la_core_pkg::OP_SUB:   res = a - b;
    la_core_pkg::OP_AND:   res = a & b;
    la_core_pkg::OP_OR:    res = a | b;
    la_core_pkg::OP_XOR:   res = a ^ b;
    la_core_pkg::OP_ADDI:  res = a + s.imm;
    la_core_pkg::OP_LU12I: res = s.imm;
    default: begin
    end
  endcase
  if (s.op inside {la_core_pkg::OP_SYSCALL, la_core_pkg::OP_BREAK, la_core_pkg::OP_INE}) begin
    r.redirect = 1'b1;
    r.target   = EENTRY;
    r.cause    = la_core_pkg::CAUSE_EXCP;
    r.ecode    = (s.op == la_core_pkg::OP_SYSCALL) ? 6'h0b :
                 (s.op == la_core_pkg::OP_BREAK) ? 6'h0c : 6'h0d;
    m_era      = (s.op == la_core_pkg::OP_INE) ? s.pc : s.pc + 32'd4;
  end else if (s.op == la_core_pkg::OP_ERTN) begin
    r.commit   = 1'b1;
    r.redirect = 1'b1;
    r.target   = m_era;
    r.cause    = la_core_pkg::CAUSE_ERTN;
  end else if (s.op == la_core_pkg::OP_IDLE) begin
    r.commit     = 1'b1;
    r.redirect   = 1'b1;
    r.target     = s.pc + 32'd4;
    r.cause      = la_core_pkg::CAUSE_REFETCH;
    r.idle_redir = 1'b1;
  end else begin
    r.commit = 1'b1;
    r.rd     = s.rd;
    r.wdata  = res;
    r.we     = (s.rd != 5'd0);
    if (r.we) begin
      m_regs[s.rd] = res;
    end
  end
  return r;
endfunction

`endif

// ==== dv/la_core_tb.sv ====
// LoongArch pipeline testbench

`default_nettype none

module la_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam la_core_pkg::word_t EENTRY = 32'h1c00_8000;

  logic                clk;
  logic                rst_n;
  logic                irq_i;
  logic                instr_valid_i;
  la_core_pkg::instr_t instr_i;
  la_core_pkg::word_t  pc_i;
  logic                commit_valid_o;
  la_core_pkg::word_t  commit_pc_o;
  logic                commit_we_o;
  la_core_pkg::areg_t  commit_rd_o;
  la_core_pkg::word_t  commit_wdata_o;
  logic                redirect_valid_o;
  la_core_pkg::word_t  redirect_pc_o;
  la_core_pkg::cause_e redirect_cause_o;
  logic [5:0]          redirect_ecode_o;
  logic                idle_o;

  int                 errors;
  int                 checks;
  int                 idle_wait;
  logic               irq_hold;
  la_core_pkg::word_t fetch_pc;
  la_core_pkg::areg_t init_rd;

  `include "la_core_model.svh"

  la_core_top #(.EENTRY(EENTRY)) la_core_top_inst (
    .clk(clk), .rst_n(rst_n), .irq_i(irq_i), .instr_valid_i(instr_valid_i),
    .instr_i(instr_i), .pc_i(pc_i), .commit_valid_o(commit_valid_o),
    .commit_pc_o(commit_pc_o), .commit_we_o(commit_we_o), .commit_rd_o(commit_rd_o),
    .commit_wdata_o(commit_wdata_o), .redirect_valid_o(redirect_valid_o),
    .redirect_pc_o(redirect_pc_o), .redirect_cause_o(redirect_cause_o),
    .redirect_ecode_o(redirect_ecode_o), .idle_o(idle_o)
  );

  always #50 clk = ~clk;

  initial begin
    #2_000_000;
    $display("timeout: the run did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic compare_word(input la_core_pkg::word_t exp, input la_core_pkg::word_t act,
                              input string msg);
    checks++;
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, msg, exp, act);
      errors++;
    end
  endtask

  // LoongArch encodings written out from the ISA manual
  function automatic la_core_pkg::instr_t encode(input slot_t s);
    case (s.op)
      la_core_pkg::OP_ADD:     return {17'h00020, s.rk, s.rj, s.rd};
      la_core_pkg::OP_SUB:     return {17'h00022, s.rk, s.rj, s.rd};
      la_core_pkg::OP_AND:     return {17'h00029, s.rk, s.rj, s.rd};
      la_core_pkg::OP_OR:      return {17'h0002a, s.rk, s.rj, s.rd};
      la_core_pkg::OP_XOR:     return {17'h0002b, s.rk, s.rj, s.rd};
      la_core_pkg::OP_ADDI:    return {10'h00a, s.imm[11:0], s.rj, s.rd};
      la_core_pkg::OP_LU12I:   return {7'h0a, s.imm[31:12], s.rd};
      la_core_pkg::OP_SYSCALL: return {17'h00056, s.imm[14:0]};
      la_core_pkg::OP_BREAK:   return {17'h00054, s.imm[14:0]};
      la_core_pkg::OP_IDLE:    return {17'h00c91, s.imm[14:0]};
      la_core_pkg::OP_ERTN:    return 32'h0648_3800;
      default:                 return s.imm;
    endcase
  endfunction

  // mostly r0..r3 so that dependencies are frequent
  function automatic la_core_pkg::areg_t pick_reg();
    logic [31:0] r;
    r = $urandom;
    if (r[3:0] < 4'd12) begin
      return {3'b000, r[5:4]};
    end
    return r[12:8];
  endfunction

  function automatic slot_t make_slot(input int mode);
    slot_t       s;
    logic [31:0] r;
    logic [31:0] p;
    s = '0;
    r = $urandom;
    p = $urandom_range(0, 99);
    s.rd  = pick_reg();
    s.rj  = pick_reg();
    s.rk  = pick_reg();
    s.imm = $urandom;
    case (r[2:0])
      3'd0:    s.op = la_core_pkg::OP_ADD;
      3'd1:    s.op = la_core_pkg::OP_SUB;
      3'd2:    s.op = la_core_pkg::OP_AND;
      3'd3:    s.op = la_core_pkg::OP_OR;
      3'd4:    s.op = la_core_pkg::OP_XOR;
      3'd5:    s.op = la_core_pkg::OP_LU12I;
      default: s.op = la_core_pkg::OP_ADDI;
    endcase
    // known contents for every register before random traffic
    if (mode == 0) begin
      s.op = la_core_pkg::OP_LU12I;
      s.rd = init_rd;
      init_rd = init_rd + 5'd1;
    end
    if (mode == 2 && r[8]) begin
      s.rd = 5'd0;
    end
    if ((mode == 3 || mode == 4) && p < 20) begin
      s.op = (r[10:9] == 2'd0) ? la_core_pkg::OP_SYSCALL :
             (r[10:9] == 2'd1) ? la_core_pkg::OP_BREAK : la_core_pkg::OP_INE;
    end else if (mode == 4 && p < 35) begin
      s.op = la_core_pkg::OP_ERTN;
    end else if (mode == 5 && p < 12) begin
      s.op = la_core_pkg::OP_IDLE;
    end
    if (s.op == la_core_pkg::OP_ADDI) begin
      s.imm = {{20{s.imm[11]}}, s.imm[11:0]};
    end else if (s.op == la_core_pkg::OP_LU12I) begin
      s.imm = {s.imm[31:12], 12'h000};
    end else if (s.op == la_core_pkg::OP_INE) begin
      // top opcode bits all ones match no supported instruction
      s.imm = {6'h3f, s.imm[25:0]};
    end
    return s;
  endfunction

  // ==============================
  // one cycle of drive and check
  // ==============================
  task automatic run_cycle(input int mode);
    slot_t   s;
    slot_t   old;
    retire_t e;
    logic    irq;
    s = make_slot(mode);
    s.valid = !m_lock;
    s.pc = fetch_pc;
    irq = irq_hold;
    if (m_lock) begin
      idle_wait++;
      irq = irq | (idle_wait >= 3);
    end else begin
      idle_wait = 0;
    end
    @(posedge clk);
    #1;
    instr_valid_i = s.valid;
    instr_i = encode(s);
    pc_i = s.pc;
    irq_i = irq;
    if (s.valid) begin
      fetch_pc = fetch_pc + 32'd4;
    end
    pipe_q.push_back(s);
    @(negedge clk);
    old = pipe_q.pop_front();
    e = model_retire(old);
    compare_word(32'(e.commit), 32'(commit_valid_o), "commit_valid_o");
    compare_word(32'(e.we), 32'(commit_we_o), "commit_we_o");
    if (e.commit) begin
      compare_word(e.pc, commit_pc_o, "commit_pc_o");
    end
    if (e.we) begin
      compare_word(32'(e.rd), 32'(commit_rd_o), "commit_rd_o");
      compare_word(e.wdata, commit_wdata_o, "commit_wdata_o");
    end
    compare_word(32'(e.redirect), 32'(redirect_valid_o), "redirect_valid_o");
    if (e.redirect) begin
      compare_word(e.target, redirect_pc_o, "redirect_pc_o");
      compare_word(32'(e.cause), 32'(redirect_cause_o), "redirect_cause_o");
      if (e.cause == la_core_pkg::CAUSE_EXCP) begin
        compare_word(32'(e.ecode), 32'(redirect_ecode_o), "redirect_ecode_o");
      end
      // everything still in flight is squashed
      foreach (pipe_q[i]) begin
        pipe_q[i].squashed = 1'b1;
      end
      fetch_pc = e.target;
    end
    compare_word(32'(m_lock | (e.idle_redir & ~irq)), 32'(idle_o), "idle_o");
    if (irq) begin
      m_lock = 1'b0;
    end else if (e.idle_redir) begin
      m_lock = 1'b1;
    end
  endtask

  task automatic run_test(input string name, input int mode, input int cycles);
    int start_err;
    start_err = errors;
    for (int i = 0; i < cycles; i++) begin
      run_cycle(mode);
    end
    $display("test %s finished with %0d errors", name, errors - start_err);
  endtask

  initial begin
    void'($urandom(32'h17d9_62ff));
    clk = 1'b0;
    rst_n = 1'b0;
    irq_i = 1'b0;
    instr_valid_i = 1'b0;
    instr_i = '0;
    pc_i = '0;
    errors = 0;
    checks = 0;
    idle_wait = 0;
    irq_hold = 1'b0;
    fetch_pc = 32'h1c00_0000;
    init_rd = 5'd1;
    m_era = '0;
    m_lock = 1'b0;
    foreach (m_regs[i]) begin
      m_regs[i] = '0;
    end
    // three empty slots stand for the stages after reset
    for (int i = 0; i < 3; i++) begin
      pipe_q.push_back('0);
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    run_test("init", 0, 31);
    run_test("alu", 1, 400);
    run_test("r0", 2, 300);
    run_test("exception", 3, 400);
    run_test("ertn", 4, 400);
    run_test("idle", 5, 400);
    irq_hold = 1'b1;
    run_test("idle_with_irq", 5, 200);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/la_core_top.sv ====
// LoongArch core pipeline top

`default_nettype none

module la_core_top #(
  parameter la_core_pkg::word_t EENTRY = 32'h1c00_0000
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                irq_i,
  input  logic                instr_valid_i,
  input  la_core_pkg::instr_t instr_i,
  input  la_core_pkg::word_t  pc_i,
  output logic                commit_valid_o,
  output la_core_pkg::word_t  commit_pc_o,
  output logic                commit_we_o,
  output la_core_pkg::areg_t  commit_rd_o,
  output la_core_pkg::word_t  commit_wdata_o,
  output logic                redirect_valid_o,
  output la_core_pkg::word_t  redirect_pc_o,
  output la_core_pkg::cause_e redirect_cause_o,
  output logic [5:0]          redirect_ecode_o,
  output logic                idle_o
);

  // decode to execute
  logic               dec_valid;
  la_core_pkg::op_e   dec_op;
  la_core_pkg::word_t dec_pc;
  la_core_pkg::areg_t dec_rj;
  la_core_pkg::areg_t dec_rk;
  la_core_pkg::areg_t dec_rd;
  la_core_pkg::word_t dec_imm;

  // execute to commit
  logic               exe_valid;
  la_core_pkg::op_e   exe_op;
  la_core_pkg::word_t exe_pc;
  logic               exe_we;
  la_core_pkg::areg_t exe_rd;
  la_core_pkg::word_t exe_result;

  logic flush;

  la_decode la_decode_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush),
    .idle_i        (idle_o),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .dec_valid_o   (dec_valid),
    .dec_op_o      (dec_op),
    .dec_pc_o      (dec_pc),
    .dec_rj_o      (dec_rj),
    .dec_rk_o      (dec_rk),
    .dec_rd_o      (dec_rd),
    .dec_imm_o     (dec_imm)
  );

  la_execute la_execute_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush),
    .dec_valid_i  (dec_valid),
    .dec_op_i     (dec_op),
    .dec_pc_i     (dec_pc),
    .dec_rj_i     (dec_rj),
    .dec_rk_i     (dec_rk),
    .dec_rd_i     (dec_rd),
    .dec_imm_i    (dec_imm),
    .exe_valid_o  (exe_valid),
    .exe_op_o     (exe_op),
    .exe_pc_o     (exe_pc),
    .exe_we_o     (exe_we),
    .exe_rd_o     (exe_rd),
    .exe_result_o (exe_result)
  );

  la_result #(
    .EENTRY (EENTRY)
  ) la_result_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .irq_i            (irq_i),
    .exe_valid_i      (exe_valid),
    .exe_op_i         (exe_op),
    .exe_pc_i         (exe_pc),
    .exe_we_i         (exe_we),
    .exe_rd_i         (exe_rd),
    .exe_result_i     (exe_result),
    .commit_valid_o   (commit_valid_o),
    .commit_pc_o      (commit_pc_o),
    .commit_we_o      (commit_we_o),
    .commit_rd_o      (commit_rd_o),
    .commit_wdata_o   (commit_wdata_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .redirect_cause_o (redirect_cause_o),
    .redirect_ecode_o (redirect_ecode_o),
    .flush_o          (flush),
    .idle_o           (idle_o)
  );

endmodule : la_core_top

`default_nettype wire

// ==== hdl/la_result.sv ====
// LoongArch core commit stage
// flush classification, redirect target, era and idle lock

`default_nettype none

module la_result #(
  parameter la_core_pkg::word_t EENTRY = 32'h1c00_0000
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                irq_i,
  input  logic                exe_valid_i,
  input  la_core_pkg::op_e    exe_op_i,
  input  la_core_pkg::word_t  exe_pc_i,
  input  logic                exe_we_i,
  input  la_core_pkg::areg_t  exe_rd_i,
  input  la_core_pkg::word_t  exe_result_i,
  output logic                commit_valid_o,
  output la_core_pkg::word_t  commit_pc_o,
  output logic                commit_we_o,
  output la_core_pkg::areg_t  commit_rd_o,
  output la_core_pkg::word_t  commit_wdata_o,
  output logic                redirect_valid_o,
  output la_core_pkg::word_t  redirect_pc_o,
  output la_core_pkg::cause_e redirect_cause_o,
  output logic [5:0]          redirect_ecode_o,
  output logic                flush_o,
  output logic                idle_o
);

  la_core_pkg::word_t  era;
  la_core_pkg::word_t  pc_next4;
  la_core_pkg::word_t  target;
  la_core_pkg::cause_e cause;
  logic [5:0]          ecode;

  logic take;
  logic excp_flush;
  logic ertn_flush;
  logic idle_flush;
  logic idle_redirect;
  logic idle_lock;

  // ==============================
  // flush classification
  // ==============================
  // the instruction right behind a redirect is already squashed
  assign take = exe_valid_i & ~redirect_valid_o;

  assign excp_flush = take & (exe_op_i inside {la_core_pkg::OP_SYSCALL,
                                               la_core_pkg::OP_BREAK,
                                               la_core_pkg::OP_INE});
  assign ertn_flush = take & (exe_op_i == la_core_pkg::OP_ERTN);
  assign idle_flush = take & (exe_op_i == la_core_pkg::OP_IDLE);

  assign pc_next4 = exe_pc_i + 32'd4;

  // target priority, exception first, then ertn, then refetch
  always_comb begin
    if (excp_flush) begin
      target = EENTRY;
      cause  = la_core_pkg::CAUSE_EXCP;
    end else if (ertn_flush) begin
      target = era;
      cause  = la_core_pkg::CAUSE_ERTN;
    end else begin
      target = pc_next4;
      cause  = la_core_pkg::CAUSE_REFETCH;
    end
  end

  always_comb begin
    case (exe_op_i)
      la_core_pkg::OP_SYSCALL: ecode = la_core_pkg::ECODE_SYS;
      la_core_pkg::OP_BREAK:   ecode = la_core_pkg::ECODE_BRK;
      la_core_pkg::OP_INE:     ecode = la_core_pkg::ECODE_INE;
      default:                 ecode = '0;
    endcase
  end

  // ==============================
  // commit and redirect registers
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_valid_o   <= 1'b0;
      commit_we_o      <= 1'b0;
      redirect_valid_o <= 1'b0;
      era              <= '0;
    end else begin
      commit_valid_o   <= take & ~excp_flush;
      commit_we_o      <= take & exe_we_i;
      redirect_valid_o <= excp_flush | ertn_flush | idle_flush;
      // syscall and break resume after themselves, INE re-executes
      if (excp_flush) begin
        era <= (exe_op_i == la_core_pkg::OP_INE) ? exe_pc_i : pc_next4;
      end
    end
  end

  always_ff @(posedge clk) begin
    commit_pc_o      <= exe_pc_i;
    commit_rd_o      <= exe_rd_i;
    commit_wdata_o   <= exe_result_i;
    redirect_pc_o    <= target;
    redirect_cause_o <= cause;
    redirect_ecode_o <= ecode;
  end

  assign flush_o = redirect_valid_o;

  // ==============================
  // idle lock
  // ==============================
  assign idle_redirect = redirect_valid_o && (redirect_cause_o == la_core_pkg::CAUSE_REFETCH);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_lock <= 1'b0;
    end else if (irq_i) begin
      idle_lock <= 1'b0;
    end else if (idle_redirect) begin
      idle_lock <= 1'b1;
    end
  end

  // shows up together with the idle redirect, a pending irq cancels it
  assign idle_o = idle_lock | (idle_redirect & ~irq_i);

  // an excepting instruction must arrive from execute without a write
  a_no_write_on_excp: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(commit_we_o && redirect_valid_o && redirect_cause_o == la_core_pkg::CAUSE_EXCP)
  );

endmodule : la_result

`default_nettype wire

// ==== hdl/la_execute.sv ====
// LoongArch core execute stage
// register file, bypass and ALU

`default_nettype none

module la_execute (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush_i,
  input  logic               dec_valid_i,
  input  la_core_pkg::op_e   dec_op_i,
  input  la_core_pkg::word_t dec_pc_i,
  input  la_core_pkg::areg_t dec_rj_i,
  input  la_core_pkg::areg_t dec_rk_i,
  input  la_core_pkg::areg_t dec_rd_i,
  input  la_core_pkg::word_t dec_imm_i,
  output logic               exe_valid_o,
  output la_core_pkg::op_e   exe_op_o,
  output la_core_pkg::word_t exe_pc_o,
  output logic               exe_we_o,
  output la_core_pkg::areg_t exe_rd_o,
  output la_core_pkg::word_t exe_result_o
);

  la_core_pkg::word_t rf [la_core_pkg::NUM_AREGS];

  la_core_pkg::word_t rj_val;
  la_core_pkg::word_t rk_val;
  la_core_pkg::word_t alu_res;
  logic               alu_we;
  logic               rf_we;
  logic               fwd_ok;

  // ==============================
  // register file
  // ==============================
  // written when the instruction leaves this stage
  assign rf_we = exe_valid_o & exe_we_o & ~flush_i;

  always_ff @(posedge clk) begin
    if (rf_we) begin
      rf[exe_rd_o] <= exe_result_o;
    end
  end

  // youngest older result still sits in the stage register
  assign fwd_ok = exe_valid_o && exe_we_o;

  assign rj_val = (dec_rj_i == '0) ? '0 :
                  (fwd_ok && exe_rd_o == dec_rj_i) ? exe_result_o :
                  rf[dec_rj_i];

  assign rk_val = (dec_rk_i == '0) ? '0 :
                  (fwd_ok && exe_rd_o == dec_rk_i) ? exe_result_o :
                  rf[dec_rk_i];

  // ==============================
  // ALU
  // ==============================
  always_comb begin
    alu_res = '0;
    alu_we  = 1'b1;
    case (dec_op_i)
      la_core_pkg::OP_ADD: begin
        alu_res = rj_val + rk_val;
      end
      la_core_pkg::OP_SUB: begin
        alu_res = rj_val - rk_val;
      end
      la_core_pkg::OP_AND: begin
        alu_res = rj_val & rk_val;
      end
      la_core_pkg::OP_OR: begin
        alu_res = rj_val | rk_val;
      end
      la_core_pkg::OP_XOR: begin
        alu_res = rj_val ^ rk_val;
      end
      la_core_pkg::OP_ADDI: begin
        alu_res = rj_val + dec_imm_i;
      end
      la_core_pkg::OP_LU12I: begin
        alu_res = dec_imm_i;
      end
      // syscall, break, ertn, idle and INE have no destination
      default: begin
        alu_we = 1'b0;
      end
    endcase
  end

  // ==============================
  // stage register
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exe_valid_o <= 1'b0;
    end else begin
      exe_valid_o <= dec_valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk) begin
    exe_op_o     <= dec_op_i;
    exe_pc_o     <= dec_pc_i;
    // r0 destination never turns into a write
    exe_we_o     <= alu_we & (dec_rd_i != '0);
    exe_rd_o     <= dec_rd_i;
    exe_result_o <= alu_res;
  end

endmodule : la_execute

`default_nettype wire

// ==== hdl/la_decode.sv ====
// LoongArch core decode stage

`default_nettype none

module la_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush_i,
  input  logic                idle_i,
  input  logic                instr_valid_i,
  input  la_core_pkg::instr_t instr_i,
  input  la_core_pkg::word_t  pc_i,
  output logic                dec_valid_o,
  output la_core_pkg::op_e    dec_op_o,
  output la_core_pkg::word_t  dec_pc_o,
  output la_core_pkg::areg_t  dec_rj_o,
  output la_core_pkg::areg_t  dec_rk_o,
  output la_core_pkg::areg_t  dec_rd_o,
  output la_core_pkg::word_t  dec_imm_o
);

  la_core_pkg::op_e   op;
  la_core_pkg::areg_t rj;
  la_core_pkg::areg_t rk;
  la_core_pkg::areg_t rd;
  la_core_pkg::word_t imm;

  logic [la_core_pkg::SI12_W-1:0] si12;
  logic [la_core_pkg::SI20_W-1:0] si20;

  assign si12 = instr_i[la_core_pkg::SI12_LSB +: la_core_pkg::SI12_W];
  assign si20 = instr_i[la_core_pkg::SI20_LSB +: la_core_pkg::SI20_W];

  // ==============================
  // opcode match
  // ==============================
  // anything not matched falls back to instruction-not-exist
  always_comb begin
    op = la_core_pkg::OP_INE;
    if (instr_i[31:la_core_pkg::OP3R_LSB] == la_core_pkg::OPC_ADD_W) begin
      op = la_core_pkg::OP_ADD;
    end else if (instr_i[31:la_core_pkg::OP3R_LSB] == la_core_pkg::OPC_SUB_W) begin
      op = la_core_pkg::OP_SUB;
    end else if (instr_i[31:la_core_pkg::OP3R_LSB] == la_core_pkg::OPC_AND) begin
      op = la_core_pkg::OP_AND;
    end else if (instr_i[31:la_core_pkg::OP3R_LSB] == la_core_pkg::OPC_OR) begin
      op = la_core_pkg::OP_OR;
    end else if (instr_i[31:la_core_pkg::OP3R_LSB] == la_core_pkg::OPC_XOR) begin
      op = la_core_pkg::OP_XOR;
    end else if (instr_i[31:la_core_pkg::OP3R_LSB] == la_core_pkg::OPC_SYSCALL) begin
      op = la_core_pkg::OP_SYSCALL;
    end else if (instr_i[31:la_core_pkg::OP3R_LSB] == la_core_pkg::OPC_BREAK) begin
      op = la_core_pkg::OP_BREAK;
    end else if (instr_i[31:la_core_pkg::OP3R_LSB] == la_core_pkg::OPC_IDLE) begin
      op = la_core_pkg::OP_IDLE;
    end else if (instr_i == la_core_pkg::OPC_ERTN) begin
      op = la_core_pkg::OP_ERTN;
    end else if (instr_i[31:la_core_pkg::OP2RI12_LSB] == la_core_pkg::OPC_ADDI_W) begin
      op = la_core_pkg::OP_ADDI;
    end else if (instr_i[31:la_core_pkg::OP1RI20_LSB] == la_core_pkg::OPC_LU12I_W) begin
      op = la_core_pkg::OP_LU12I;
    end
  end

  // source and destination select, unused slots read r0
  always_comb begin
    rj  = '0;
    rk  = '0;
    rd  = '0;
    imm = '0;
    case (op)
      la_core_pkg::OP_ADD, la_core_pkg::OP_SUB, la_core_pkg::OP_AND,
      la_core_pkg::OP_OR, la_core_pkg::OP_XOR: begin
        rj = instr_i[la_core_pkg::RJ_LSB +: 5];
        rk = instr_i[la_core_pkg::RK_LSB +: 5];
        rd = instr_i[la_core_pkg::RD_LSB +: 5];
      end
      la_core_pkg::OP_ADDI: begin
        rj  = instr_i[la_core_pkg::RJ_LSB +: 5];
        rd  = instr_i[la_core_pkg::RD_LSB +: 5];
        imm = {{(32 - la_core_pkg::SI12_W){si12[la_core_pkg::SI12_W-1]}}, si12};
      end
      la_core_pkg::OP_LU12I: begin
        rd  = instr_i[la_core_pkg::RD_LSB +: 5];
        imm = {si20, 12'h000};
      end
      default: begin
      end
    endcase
  end

  // ==============================
  // stage register
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= instr_valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk) begin
    dec_op_o  <= op;
    dec_pc_o  <= pc_i;
    dec_rj_o  <= rj;
    dec_rk_o  <= rk;
    dec_rd_o  <= rd;
    dec_imm_o <= imm;
  end

  // fetch must stay quiet while the core sleeps, the redirect cycle itself drops input
  a_no_issue_while_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (idle_i && !flush_i) |-> !instr_valid_i
  );

endmodule : la_decode

`default_nettype wire

// ==== hdl/la_core_pkg.sv ====
// LoongArch core shared types
// word types, opcodes and exception codes

`default_nettype none

package la_core_pkg;

  // ==============================
  // word types
  // ==============================
  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  areg_t;

  localparam int NUM_AREGS = 32;

  // decoded operation class
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LU12I,
    OP_SYSCALL,
    OP_BREAK,
    OP_ERTN,
    OP_IDLE,
    OP_INE
  } op_e;

  // redirect cause seen by the fetch side
  typedef enum logic [1:0] {
    CAUSE_EXCP    = 2'd0,
    CAUSE_ERTN    = 2'd1,
    CAUSE_REFETCH = 2'd2
  } cause_e;

  // ==============================
  // instruction fields
  // ==============================
  // lowest bit of each major opcode slice, the slice runs up to bit 31
  localparam int OP3R_LSB    = 15;
  localparam int OP2RI12_LSB = 22;
  localparam int OP1RI20_LSB = 25;

  localparam int RD_LSB   = 0;
  localparam int RJ_LSB   = 5;
  localparam int RK_LSB   = 10;
  localparam int SI12_LSB = 10;
  localparam int SI12_W   = 12;
  localparam int SI20_LSB = 5;
  localparam int SI20_W   = 20;

  // 3R format and code-carrying formats, match on bits 31:15
  localparam logic [16:0] OPC_ADD_W   = 17'h00020;
  localparam logic [16:0] OPC_SUB_W   = 17'h00022;
  localparam logic [16:0] OPC_AND     = 17'h00029;
  localparam logic [16:0] OPC_OR      = 17'h0002a;
  localparam logic [16:0] OPC_XOR     = 17'h0002b;
  localparam logic [16:0] OPC_BREAK   = 17'h00054;
  localparam logic [16:0] OPC_SYSCALL = 17'h00056;
  localparam logic [16:0] OPC_IDLE    = 17'h00c91;

  // 2RI12 match on bits 31:22, 1RI20 on bits 31:25
  localparam logic [9:0] OPC_ADDI_W  = 10'h00a;
  localparam logic [6:0] OPC_LU12I_W = 7'h0a;

  // ertn has no operand fields at all
  localparam instr_t OPC_ERTN = 32'h0648_3800;

  // ==============================
  // exception codes
  // ==============================
  localparam logic [5:0] ECODE_SYS = 6'h0b;
  localparam logic [5:0] ECODE_BRK = 6'h0c;
  localparam logic [5:0] ECODE_INE = 6'h0d;

endpackage : la_core_pkg

`default_nettype wire
